// File: source/xy_sample_pkg.sv
`default_nettype none

// widths and sample-word types shared by the XY capture path
package xy_sample_pkg;

  // default width of one ADC coordinate
  localparam int data_bits = 10;

  // one bit each for red, green and blue
  localparam int color_bits = 3;

  // X/Y conversion latency of the ADC in adc_clk cycles, taken from its data sheet
  localparam int adc_latency = 7;

  // one X or Y sample as it comes off the ADC pins
  typedef logic [data_bits-1:0] coord_t;

  // colour bits, packed as {red, green, blue}
  typedef logic [color_bits-1:0] color_t;

endpackage

`default_nettype wire

// File: source/capture_cfg_pkg.sv
`default_nettype none

// configuration port layout for the capture register block
package capture_cfg_pkg;

  localparam int cfg_addr_bits = 4;
  localparam int cfg_data_bits = 8;

  typedef logic [cfg_addr_bits-1:0] cfg_addr_t;
  typedef logic [cfg_data_bits-1:0] cfg_data_t;

  // control register holds the capture enable and the keep_dark switch
  localparam cfg_addr_t addr_ctrl = 4'd0;
  // status register, writing a one to the overflow bit clears the sticky flag
  localparam cfg_addr_t addr_status = 4'd1;

  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_keep_dark_bit = 1;
  localparam int status_overflow_bit = 0;

endpackage

`default_nettype wire

// File: source/sample_delay.sv
`timescale 1ns/1ps
`default_nettype none

// fixed-depth delay line for the colour bits
// colour is valid at the pins right away while X/Y trail by the ADC latency,
// so the colour is held back DEPTH cycles to pair up with its coordinates
module sample_delay #(
  parameter int DEPTH = 7
) (
  input  logic                  clk,
  input  xy_sample_pkg::color_t in,
  output xy_sample_pkg::color_t out
);

  xy_sample_pkg::color_t stages [DEPTH];

  // stage 0 takes the pins, each later stage takes the one before it
  always_ff @(posedge clk) begin
    stages[0] <= in;
    for (int i = 1; i < DEPTH; i++) begin
      stages[i] <= stages[i-1];
    end
  end

  // the colour captured DEPTH edges ago
  assign out = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: source/cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// dual-clock FIFO with gray-coded pointers
// each pointer crosses into the other domain through two flops, and the read
// data falls through so r_data shows the head word whenever r_empty is low
module cdc_fifo #(
  parameter int DATA_WIDTH = 23,
  parameter int ADDR_BITS  = 3
) (
  input  logic                  w_clk,
  input  logic                  w_reset,
  input  logic                  w_inc,
  input  logic [DATA_WIDTH-1:0] w_data,
  output logic                  w_full,

  input  logic                  r_clk,
  input  logic                  r_reset,
  input  logic                  r_inc,
  output logic                  r_empty,
  output logic [DATA_WIDTH-1:0] r_data
);

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // pointers carry one extra bit so that full and empty can be told apart
  logic [ADDR_BITS:0] w_bin;
  logic [ADDR_BITS:0] w_bin_next;
  logic [ADDR_BITS:0] w_gray;
  logic [ADDR_BITS:0] w_rq1;
  logic [ADDR_BITS:0] w_rq2;
  logic               w_push;

  logic [ADDR_BITS:0] r_bin;
  logic [ADDR_BITS:0] r_bin_next;
  logic [ADDR_BITS:0] r_gray;
  logic [ADDR_BITS:0] r_wq1;
  logic [ADDR_BITS:0] r_wq2;
  logic               r_pop;

  // write side
  assign w_push     = w_inc && !w_full;
  assign w_bin_next = w_bin + {{ADDR_BITS{1'b0}}, w_push};

  always_ff @(posedge w_clk) begin
    if (w_reset) begin
      w_bin  <= '0;
      w_gray <= '0;
      w_rq1  <= '0;
      w_rq2  <= '0;
    end else begin
      w_bin  <= w_bin_next;
      w_gray <= (w_bin_next >> 1) ^ w_bin_next;
      // read pointer coming over from r_clk
      w_rq1  <= r_gray;
      w_rq2  <= w_rq1;
    end
  end

  always_ff @(posedge w_clk) begin
    if (w_push) begin
      mem[w_bin[ADDR_BITS-1:0]] <= w_data;
    end
  end

  // full when the write pointer is one lap ahead of the synchronized read pointer,
  // which in gray code means the two top bits differ and the rest agree
  assign w_full = (w_gray == {~w_rq2[ADDR_BITS:ADDR_BITS-1], w_rq2[ADDR_BITS-2:0]});

  // read side
  assign r_pop      = r_inc && !r_empty;
  assign r_bin_next = r_bin + {{ADDR_BITS{1'b0}}, r_pop};

  always_ff @(posedge r_clk) begin
    if (r_reset) begin
      r_bin  <= '0;
      r_gray <= '0;
      r_wq1  <= '0;
      r_wq2  <= '0;
    end else begin
      r_bin  <= r_bin_next;
      r_gray <= (r_bin_next >> 1) ^ r_bin_next;
      r_wq1  <= w_gray;
      r_wq2  <= r_wq1;
    end
  end

  // a write shows up here two r_clk edges after its pointer settles
  assign r_empty = (r_gray == r_wq2);
  assign r_data  = mem[r_bin[ADDR_BITS-1:0]];

  // the writer is expected to hold off on full and the reader on empty
  assert property (@(posedge w_clk) disable iff (w_reset) !(w_inc && w_full))
    else $error("cdc_fifo write while full");
  assert property (@(posedge r_clk) disable iff (r_reset) !(r_inc && r_empty))
    else $error("cdc_fifo read while empty");

endmodule

`default_nettype wire

// File: source/capture_regs.sv
`timescale 1ns/1ps
`default_nettype none

// configuration registers for the capture path, written over a four-phase
// req/ack port in the clk domain
module capture_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cfg_req,
  input  capture_cfg_pkg::cfg_addr_t cfg_addr,
  input  capture_cfg_pkg::cfg_data_t cfg_wdata,
  output logic                       cfg_ack,
  input  logic                       overflow_event,
  output logic                       enable,
  output logic                       keep_dark,
  output logic                       overflow
);

  logic write_strobe;
  logic ctrl_write;
  logic overflow_clear;

  // a write happens once, on the edge where req is up and ack is still down
  assign write_strobe = cfg_req && !cfg_ack;
  assign ctrl_write   = write_strobe && (cfg_addr == capture_cfg_pkg::addr_ctrl);
  assign overflow_clear = write_strobe && (cfg_addr == capture_cfg_pkg::addr_status)
                          && cfg_wdata[capture_cfg_pkg::status_overflow_bit];

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_ack   <= 1'b0;
      enable    <= 1'b0;
      keep_dark <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      // ack follows req one edge late, which gives both the rise after the write
      // and the fall after the master lets go of req
      cfg_ack <= cfg_req;
      if (ctrl_write) begin
        enable    <= cfg_wdata[capture_cfg_pkg::ctrl_enable_bit];
        keep_dark <= cfg_wdata[capture_cfg_pkg::ctrl_keep_dark_bit];
      end
      // a drop in the same cycle as a clear wins, so no overflow goes unreported
      if (overflow_event) begin
        overflow <= 1'b1;
      end else if (overflow_clear) begin
        overflow <= 1'b0;
      end
    end
  end

  // handshake checks against the master
  // a new request may only start once the ack of the previous one has dropped
  assert property (@(posedge clk) disable iff (reset) $rose(cfg_req) |-> !cfg_ack)
    else $error("cfg_req rose while cfg_ack was still high");
  assert property (@(posedge clk) disable iff (reset)
    (cfg_req && !cfg_ack) |=> $stable(cfg_addr))
    else $error("cfg_addr changed before cfg_ack");

endmodule

`default_nettype wire

// File: source/xy_capture.sv
`timescale 1ns/1ps
`default_nettype none

// beam sample capture
// pairs the colour with its X/Y, keeps lit (or all) samples while enabled,
// and moves them from adc_clk over to a valid/ready stream on clk
module xy_capture #(
  parameter int DATA_BITS      = 10,
  parameter int ADC_LATENCY    = 7,
  parameter int FIFO_ADDR_BITS = 3
) (
  input  logic                  clk,
  input  logic                  adc_clk,
  input  logic                  reset,

  input  logic                  enable,
  input  logic                  keep_dark,
  output logic                  overflow_event,

  input  xy_sample_pkg::coord_t adc_x_io,
  input  xy_sample_pkg::coord_t adc_y_io,
  input  xy_sample_pkg::color_t adc_color_io,

  output logic                  tvalid,
  input  logic                  tready,
  output xy_sample_pkg::coord_t adc_x,
  output xy_sample_pkg::coord_t adc_y,
  output xy_sample_pkg::color_t adc_color
);

  // one FIFO word is {x, y, colour}
  localparam int FIFO_WIDTH = 2 * DATA_BITS + $bits(xy_sample_pkg::color_t);

  // the coordinate ports are typed, so the width parameter has to agree with them
  if (DATA_BITS != $bits(xy_sample_pkg::coord_t)) begin : g_width_check
    $error("DATA_BITS does not match xy_sample_pkg::coord_t");
  end

  logic                  enable_meta;
  logic                  enable_sync;
  logic                  keep_dark_meta;
  logic                  keep_dark_sync;
  xy_sample_pkg::color_t color_d;
  logic                  keep;
  logic                  drop_toggle;

  logic                  fifo_w_inc;
  logic                  fifo_w_full;
  logic [FIFO_WIDTH-1:0] fifo_w_data;
  logic                  fifo_r_inc;
  logic                  fifo_r_empty;
  logic [FIFO_WIDTH-1:0] fifo_r_data;

  logic                  drop_meta;
  logic                  drop_sync;
  logic                  drop_seen;

  // controls come from the register block on clk and are only levels, so two flops do
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      enable_meta    <= 1'b0;
      enable_sync    <= 1'b0;
      keep_dark_meta <= 1'b0;
      keep_dark_sync <= 1'b0;
    end else begin
      enable_meta    <= enable;
      enable_sync    <= enable_meta;
      keep_dark_meta <= keep_dark;
      keep_dark_sync <= keep_dark_meta;
    end
  end

  sample_delay #(
    .DEPTH(ADC_LATENCY)
  ) color_delay (
    .clk(adc_clk),
    .in (adc_color_io),
    .out(color_d)
  );

  // X/Y on the pins now belong to the colour that went in ADC_LATENCY edges ago
  assign fifo_w_data = {adc_x_io, adc_y_io, color_d};
  assign keep        = enable_sync && ((|color_d) || keep_dark_sync);
  assign fifo_w_inc  = keep && !fifo_w_full;

  // every dropped sample flips the toggle, clk turns each flip into one pulse
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      drop_toggle <= 1'b0;
    end else if (keep && fifo_w_full) begin
      drop_toggle <= ~drop_toggle;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      drop_meta <= 1'b0;
      drop_sync <= 1'b0;
      drop_seen <= 1'b0;
    end else begin
      drop_meta <= drop_toggle;
      drop_sync <= drop_meta;
      drop_seen <= drop_sync;
    end
  end

  assign overflow_event = drop_sync ^ drop_seen;

  cdc_fifo #(
    .DATA_WIDTH(FIFO_WIDTH),
    .ADDR_BITS (FIFO_ADDR_BITS)
  ) sample_fifo (
    .w_clk  (adc_clk),
    .w_reset(reset),
    .w_inc  (fifo_w_inc),
    .w_data (fifo_w_data),
    .w_full (fifo_w_full),
    .r_clk  (clk),
    .r_reset(reset),
    .r_inc  (fifo_r_inc),
    .r_empty(fifo_r_empty),
    .r_data (fifo_r_data)
  );

  // the output register loads whenever it is empty or being emptied this cycle
  assign fifo_r_inc = !fifo_r_empty && (!tvalid || tready);

  always_ff @(posedge clk) begin
    if (reset) begin
      tvalid <= 1'b0;
    end else if (!tvalid || tready) begin
      tvalid <= !fifo_r_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_r_inc) begin
      {adc_x, adc_y, adc_color} <= fifo_r_data;
    end
  end

  // a stalled word must not move or change
  assert property (@(posedge clk) disable iff (reset)
    (tvalid && !tready) |=> (tvalid && $stable({adc_x, adc_y, adc_color})))
    else $error("output word changed while stalled");

endmodule

`default_nettype wire

// File: source/xy_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

// XY display capture: configuration registers beside the capture path
module xy_capture_top #(
  parameter int DATA_BITS      = xy_sample_pkg::data_bits,
  parameter int ADC_LATENCY    = xy_sample_pkg::adc_latency,
  parameter int FIFO_ADDR_BITS = 3
) (
  input  logic                       clk,
  input  logic                       adc_clk,
  input  logic                       reset,

  // four-phase configuration port, clk domain
  input  logic                       cfg_req,
  input  capture_cfg_pkg::cfg_addr_t cfg_addr,
  input  capture_cfg_pkg::cfg_data_t cfg_wdata,
  output logic                       cfg_ack,

  // ADC pins, adc_clk domain
  input  xy_sample_pkg::coord_t      adc_x_io,
  input  xy_sample_pkg::coord_t      adc_y_io,
  input  xy_sample_pkg::color_t      adc_color_io,

  // sample stream, clk domain
  output logic                       tvalid,
  input  logic                       tready,
  output xy_sample_pkg::coord_t      adc_x,
  output xy_sample_pkg::coord_t      adc_y,
  output xy_sample_pkg::color_t      adc_color,

  output logic                       overflow
);

  logic enable;
  logic keep_dark;
  logic overflow_event;

  capture_regs regs (
    .clk           (clk),
    .reset         (reset),
    .cfg_req       (cfg_req),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_ack       (cfg_ack),
    .overflow_event(overflow_event),
    .enable        (enable),
    .keep_dark     (keep_dark),
    .overflow      (overflow)
  );

  xy_capture #(
    .DATA_BITS     (DATA_BITS),
    .ADC_LATENCY   (ADC_LATENCY),
    .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
  ) capture (
    .clk           (clk),
    .adc_clk       (adc_clk),
    .reset         (reset),
    .enable        (enable),
    .keep_dark     (keep_dark),
    .overflow_event(overflow_event),
    .adc_x_io      (adc_x_io),
    .adc_y_io      (adc_y_io),
    .adc_color_io  (adc_color_io),
    .tvalid        (tvalid),
    .tready        (tready),
    .adc_x         (adc_x),
    .adc_y         (adc_y),
    .adc_color     (adc_color)
  );

endmodule

`default_nettype wire

// File: verif/xy_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the XY capture top level
// a model follows the pins at every adc_clk edge and queues the words that should
// come out, and a comparing process pops that queue on every stream transfer
module xy_capture_tb;

  localparam int clk_period = 100;
  localparam int adc_period = 260;
  localparam int db = xy_sample_pkg::data_bits;
  localparam int latency = xy_sample_pkg::adc_latency;

  // test lengths in adc_clk cycles, the overhead covers flushing, writes and draining
  localparam int idle_run = 60;
  localparam int stream_run = 120;
  localparam int stall_run = 40;
  localparam int test_overhead = 60;
  localparam int watchdog_ns =
    2 * adc_period * (idle_run + 3 * stream_run + stall_run + 5 * test_overhead);
  // clk cycles without a word before a drain gives up
  localparam int drain_limit = 40;

  localparam int pins_dark = 0;
  localparam int pins_random = 1;
  localparam int pins_lit = 2;
  localparam int ready_always = 0;
  localparam int ready_random = 1;
  localparam int ready_held = 2;

  // one stream word, {x, y, colour}
  typedef logic [2*db+$bits(xy_sample_pkg::color_t)-1:0] word_t;

  logic                       clk;
  logic                       adc_clk;
  logic                       reset;
  logic                       cfg_req;
  capture_cfg_pkg::cfg_addr_t cfg_addr;
  capture_cfg_pkg::cfg_data_t cfg_wdata;
  logic                       cfg_ack;
  xy_sample_pkg::coord_t      adc_x_io;
  xy_sample_pkg::coord_t      adc_y_io;
  xy_sample_pkg::color_t      adc_color_io;
  logic                       tvalid;
  logic                       tready;
  xy_sample_pkg::coord_t      adc_x;
  xy_sample_pkg::coord_t      adc_y;
  xy_sample_pkg::color_t      adc_color;
  logic                       overflow;

  integer seed;
  int     pin_mode;
  int     ready_mode;
  int     stall_left;
  string  test_name;
  int     tests;
  int     errors;
  int     errors_at_start;
  int     words;
  int     test_words;

  // model state, the old controls stay in use while a new setting may still be crossing
  xy_sample_pkg::color_t color_hist[$];
  word_t                 exp_q[$];
  bit                    opt_q[$];
  bit                    model_en;
  bit                    model_kd;
  bit                    old_en;
  bit                    old_kd;
  int                    uncertain_left;
  bit                    was_stalled;
  word_t                 held_word;

  xy_capture_top #(
    .DATA_BITS     (db),
    .ADC_LATENCY   (latency),
    .FIFO_ADDR_BITS(3)
  ) UUT (
    .clk         (clk),
    .adc_clk     (adc_clk),
    .reset       (reset),
    .cfg_req     (cfg_req),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_ack     (cfg_ack),
    .adc_x_io    (adc_x_io),
    .adc_y_io    (adc_y_io),
    .adc_color_io(adc_color_io),
    .tvalid      (tvalid),
    .tready      (tready),
    .adc_x       (adc_x),
    .adc_y       (adc_y),
    .adc_color   (adc_color),
    .overflow    (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // the 17 ns offset keeps every adc_clk edge away from every clk edge
  initial begin
    adc_clk = 1'b0;
    #17;
    forever #(adc_period / 2) adc_clk = ~adc_clk;
  end

  // a sample is kept when capture is on and it is lit, or dark ones are wanted too
  function automatic bit is_kept(input xy_sample_pkg::color_t c, input bit en, input bit kd);
    return en && ((c != '0) || kd);
  endfunction

  // X/Y at this edge belong to the colour seen latency edges ago
  // samples whose fate depends on a setting still crossing are queued as optional
  function automatic void expected_sample(input xy_sample_pkg::coord_t x,
                                          input xy_sample_pkg::coord_t y,
                                          input xy_sample_pkg::color_t c);
    xy_sample_pkg::color_t d;
    bit                    keep_new;
    bit                    keep_old;
    color_hist.push_back(c);
    if (color_hist.size() <= latency) begin
      return;
    end
    d = color_hist.pop_front();
    keep_new = is_kept(d, model_en, model_kd);
    keep_old = keep_new;
    if (uncertain_left > 0) begin
      keep_old = is_kept(d, old_en, old_kd);
      uncertain_left--;
    end
    if (keep_new || keep_old) begin
      exp_q.push_back({x, y, d});
      opt_q.push_back(keep_new != keep_old);
    end
  endfunction

  function automatic capture_cfg_pkg::cfg_data_t ctrl_word(input bit en, input bit kd);
    capture_cfg_pkg::cfg_data_t w;
    w = '0;
    w[capture_cfg_pkg::ctrl_enable_bit] = en;
    w[capture_cfg_pkg::ctrl_keep_dark_bit] = kd;
    return w;
  endfunction

  task automatic report_error(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  always @(posedge adc_clk) begin
    if (!reset) begin
      expected_sample(adc_x_io, adc_y_io, adc_color_io);
    end
  end

  // pins change on the falling adc_clk edge, X/Y are always random
  always @(negedge adc_clk) begin : drive_pins
    logic [31:0] r;
    r = $random(seed);
    adc_x_io <= r[db-1:0];
    adc_y_io <= r[2*db-1:db];
    if (pin_mode == pins_dark) begin
      adc_color_io <= '0;
    end else if (pin_mode == pins_lit && r[2*db+2:2*db] == 3'b000) begin
      adc_color_io <= 3'b100;
    end else begin
      adc_color_io <= r[2*db+2:2*db];
    end
  end

  // tready either stays high, stays low, or stalls 0 to 2 cycles after each high cycle
  always @(negedge clk) begin
    if (ready_mode == ready_always) begin
      tready = 1'b1;
    end else if (ready_mode == ready_held) begin
      tready = 1'b0;
    end else if (stall_left > 0) begin
      tready = 1'b0;
      stall_left--;
    end else begin
      tready = 1'b1;
      stall_left = $unsigned($random(seed)) % 3;
    end
  end

  always @(posedge clk) begin : compare_stream
    word_t actual;
    actual = {adc_x, adc_y, adc_color};
    if (reset) begin
      was_stalled = 1'b0;
    end else begin
      if (was_stalled) begin
        assert (tvalid && actual == held_word) else begin
          errors++;
          $display("mismatch %s stalled word expected %h actual %h",
                   test_name, held_word, actual);
        end
      end
      was_stalled = tvalid && !tready;
      held_word = actual;
      if (tvalid && tready) begin
        // optional words the DUT did not keep are skipped
        while (exp_q.size() > 0 && opt_q[0] && exp_q[0] != actual) begin
          void'(exp_q.pop_front());
          void'(opt_q.pop_front());
        end
        assert (exp_q.size() > 0) else begin
          report_error($sformatf("word %h came out with no word expected", actual));
        end
        if (exp_q.size() > 0) begin
          words++;
          test_words++;
          assert (exp_q[0] == actual) else begin
            errors++;
            $display("mismatch %s expected %h actual %h", test_name, exp_q[0], actual);
          end
          void'(exp_q.pop_front());
          void'(opt_q.pop_front());
        end
      end
    end
  end

  task automatic adc_cycles(input int mode, input int n);
    pin_mode = mode;
    repeat (n) @(posedge adc_clk);
  endtask

  // four-phase write, a control write also moves the model to the new setting
  task automatic cfg_write(input capture_cfg_pkg::cfg_addr_t addr,
                           input capture_cfg_pkg::cfg_data_t data);
    int n;
    @(negedge clk);
    assert (!cfg_ack) else report_error("cfg_ack was high before the request");
    cfg_req = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cfg_ack && n < 8);
    assert (cfg_ack) else report_error("cfg_ack did not rise after cfg_req");
    if (addr == capture_cfg_pkg::addr_ctrl) begin
      old_en = model_en;
      old_kd = model_kd;
      model_en = data[capture_cfg_pkg::ctrl_enable_bit];
      model_kd = data[capture_cfg_pkg::ctrl_keep_dark_bit];
      uncertain_left = 3;
    end
    cfg_req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cfg_ack && n < 8);
    assert (!cfg_ack) else report_error("cfg_ack did not fall after cfg_req dropped");
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_words = 0;
    errors_at_start = errors;
    tests++;
  endtask

  // flush the colour delay line, stop capture and wait for the stream to run dry
  task automatic finish_test(input bit allow_loss);
    int idle;
    int lost;
    adc_cycles(pins_dark, latency + 1);
    cfg_write(capture_cfg_pkg::addr_ctrl, ctrl_word(1'b0, 1'b0));
    adc_cycles(pins_dark, 4);
    idle = 0;
    while (idle < drain_limit && !(exp_q.size() == 0 && !tvalid)) begin
      @(negedge clk);
      idle = tvalid ? 0 : idle + 1;
    end
    lost = 0;
    foreach (opt_q[i]) begin
      if (!opt_q[i]) begin
        lost++;
      end
    end
    assert (allow_loss || lost == 0) else begin
      report_error($sformatf("%0d expected words never came out", lost));
    end
    exp_q.delete();
    opt_q.delete();
    $display("test %s: %0d words, %0d errors", test_name, test_words, errors - errors_at_start);
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout after %0d ns, the run did not finish", watchdog_ns);
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed = 32'ha999_230c;
    reset = 1'b1;
    cfg_req = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    adc_x_io = '0;
    adc_y_io = '0;
    adc_color_io = '0;
    tready = 1'b1;
    pin_mode = pins_dark;
    ready_mode = ready_always;
    stall_left = 0;
    model_en = 1'b0;
    model_kd = 1'b0;
    old_en = 1'b0;
    old_kd = 1'b0;
    uncertain_left = 0;
    tests = 0;
    errors = 0;
    words = 0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("reset_idle");
    assert (!tvalid && !cfg_ack && !overflow) else begin
      report_error("tvalid, cfg_ack or overflow was high after reset");
    end
    adc_cycles(pins_random, idle_run);
    finish_test(1'b0);

    start_test("lit_only");
    cfg_write(capture_cfg_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0));
    adc_cycles(pins_dark, 4);
    adc_cycles(pins_random, stream_run);
    finish_test(1'b0);

    start_test("keep_dark");
    cfg_write(capture_cfg_pkg::addr_ctrl, ctrl_word(1'b1, 1'b1));
    adc_cycles(pins_dark, 4);
    adc_cycles(pins_random, stream_run);
    finish_test(1'b0);

    // the write to address 5 would turn keep_dark on if it were decoded as control
    start_test("stalls");
    cfg_write(capture_cfg_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0));
    cfg_write(4'h5, 8'h03);
    adc_cycles(pins_dark, 4);
    ready_mode = ready_random;
    adc_cycles(pins_random, stream_run);
    ready_mode = ready_always;
    finish_test(1'b0);

    start_test("overflow");
    cfg_write(capture_cfg_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0));
    adc_cycles(pins_dark, 4);
    ready_mode = ready_held;
    adc_cycles(pins_lit, stall_run);
    adc_cycles(pins_dark, latency + 4);
    assert (overflow) else report_error("overflow did not set after the FIFO filled");
    ready_mode = ready_always;
    // bit 0 of the status register clears the sticky flag
    cfg_write(capture_cfg_pkg::addr_status, 8'h01);
    assert (!overflow) else report_error("overflow did not clear");
    finish_test(1'b1);

    $display("%0d tests, %0d words compared, %0d errors", tests, words, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/xy_sample_pkg.sv
source/capture_cfg_pkg.sv
source/sample_delay.sv
source/cdc_fifo.sv
source/capture_regs.sv
source/xy_capture.sv
source/xy_capture_top.sv
verif/xy_capture_tb.sv

// File: Bender.yml
package:
  name: xy_capture

sources:
  - files:
      - source/xy_sample_pkg.sv
      - source/capture_cfg_pkg.sv
      - source/sample_delay.sv
      - source/cdc_fifo.sv
      - source/capture_regs.sv
      - source/xy_capture.sv
      - source/xy_capture_top.sv
  - target: test
    files:
      - verif/xy_capture_tb.sv
